// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    typedef enum logic [6:0] {
        LOAD           = 7'b0000011,
        STORE          = 7'b0100011,
        ARITHMETIC     = 7'b0110011,
        ARITHMETIC_IMM = 7'b0010011,
        BRANCH         = 7'b1100011,
        JAL            = 7'b1101111,
        JALR           = 7'b1100111,
        ECALL          = 7'b1110011
    } opcode_e;

    // What the sequencer asks of the ALU; the ALU picks the operation itself.
    typedef enum logic [1:0] {
        CLASS_ADD        = 2'd0, // Addresses and the PC increment.
        CLASS_BRANCH_CMP = 2'd1, // Subtract so the zero flag compares rs1 and rs2.
        CLASS_R_FUNC     = 2'd2,
        CLASS_I_FUNC     = 2'd3
    } alu_class_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [3:0] {
        ST_FETCH         = 4'd0,
        ST_DECODE        = 4'd1,
        ST_MEM_ADDR      = 4'd2,
        ST_MEM_READ      = 4'd3,
        ST_MEM_WRITE     = 4'd4,
        ST_WRITEBACK     = 4'd5,
        ST_EXEC_R        = 4'd6,
        ST_EXEC_I        = 4'd7,
        ST_ALU_WRITEBACK = 4'd8,
        ST_BRANCH        = 4'd9,
        ST_JAL_LINK      = 4'd10,
        ST_JAL_JUMP      = 4'd11,
        ST_JALR_LINK     = 4'd12,
        ST_JALR_JUMP     = 4'd13,
        ST_HALT          = 4'd14
    } ctrl_state_e;

    typedef struct packed {
        logic       pc_write;
        logic       pc_write_cond;
        logic       pc_source;  // 0 takes the ALU result, 1 the ALU-out register.
        logic       i_or_d;     // 0 addresses memory with the PC, 1 with ALU-out.
        logic       mem_start;
        logic       mem_write;
        logic       ir_write;
        logic       mdr_write;
        logic       mem_to_reg;
        logic       reg_write;
        logic       link;       // Write-back of the return address.
        logic       alu_src_a;
        logic [1:0] alu_src_b;
        alu_class_e alu_class;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] addr; // Word address.
        logic [xlen-1:0] wdata;
        logic            write_en;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== alu_unit.sv ====
`default_nettype none

module alu_unit (
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  cpu_pkg::alu_class_e      alu_class,
    input  logic [2:0]               funct3,
    input  logic                     funct7_5,
    output logic [cpu_pkg::xlen-1:0] result,
    output logic                     zero
);
    import cpu_pkg::*;

    alu_op_e op;

    always_comb begin
        op = ALU_ADD;
        case (alu_class)
            CLASS_BRANCH_CMP: op = ALU_SUB;
            CLASS_R_FUNC, CLASS_I_FUNC: begin
                case (funct3)
                    3'b000: begin
                        // Only R-type reads funct7; addi may carry any bit 30.
                        op = (alu_class == CLASS_R_FUNC && funct7_5) ? ALU_SUB : ALU_ADD;
                    end
                    3'b010:  op = ALU_SLT;
                    3'b100:  op = ALU_XOR;
                    3'b110:  op = ALU_OR;
                    3'b111:  op = ALU_AND;
                    default: op = ALU_ADD;
                endcase
            end
            default: op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (op)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     write_en,
    input  logic [cpu_pkg::xlen-1:0] write_data,
    output logic [cpu_pkg::xlen-1:0] read1,
    output logic [cpu_pkg::xlen-1:0] read2
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [32];

    // No register changes while the core is held in reset.
    always_ff @(posedge clk) begin
        if (!reset && write_en && rd != 5'd0) begin
            regs[rd] <= write_data;
        end
    end

    assign read1 = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 is never stored.
    assign read2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`default_nettype none

module imm_gen (
    input  logic [cpu_pkg::xlen-1:0] instr,
    output logic [cpu_pkg::xlen-1:0] imm
);
    import cpu_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            LOAD, ARITHMETIC_IMM, JALR: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type and ecall have no immediate.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== control_fsm.sv ====
`default_nettype none

module control_fsm (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::opcode_e  opcode,
    input  logic              branch_taken,
    input  logic              mem_done,
    output cpu_pkg::ctrl_t    ctrl,
    output logic              halted
);
    import cpu_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH: begin
                if (mem_done) begin
                    state_next = ST_DECODE;
                end
            end
            ST_DECODE: begin
                case (opcode)
                    LOAD, STORE:    state_next = ST_MEM_ADDR;
                    ARITHMETIC:     state_next = ST_EXEC_R;
                    ARITHMETIC_IMM: state_next = ST_EXEC_I;
                    BRANCH:         state_next = ST_BRANCH;
                    JAL:            state_next = ST_JAL_LINK;
                    JALR:           state_next = ST_JALR_LINK;
                    default:        state_next = ST_HALT; // ecall, and anything unsupported.
                endcase
            end
            ST_MEM_ADDR: begin
                state_next = (opcode == LOAD) ? ST_MEM_READ : ST_MEM_WRITE;
            end
            ST_MEM_READ: begin
                if (mem_done) begin
                    state_next = ST_WRITEBACK;
                end
            end
            ST_MEM_WRITE: begin
                if (mem_done) begin
                    state_next = ST_FETCH;
                end
            end
            ST_EXEC_R, ST_EXEC_I: state_next = ST_ALU_WRITEBACK;
            ST_JAL_LINK:          state_next = ST_JAL_JUMP;
            ST_JALR_LINK:         state_next = ST_JALR_JUMP;
            ST_HALT:              state_next = ST_HALT;
            default:              state_next = ST_FETCH;
        endcase
    end

    // The memory states hold mem_start for their whole length.
    // The port takes the request as soon as its previous handshake is over.
    always_comb begin
        ctrl = '0;
        case (state)
            ST_FETCH: begin
                ctrl.mem_start = 1'b1;
                ctrl.ir_write  = 1'b1;
                ctrl.alu_src_b = 2'b01;
                ctrl.pc_write  = mem_done; // PC moves on together with the IR.
            end
            ST_DECODE: begin
                ctrl.alu_src_b = 2'b10; // Branch and jal target into ALU-out.
            end
            ST_MEM_ADDR: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = 2'b10;
            end
            ST_MEM_READ, ST_MEM_WRITE: begin
                ctrl.mem_start = 1'b1;
                ctrl.i_or_d    = 1'b1;
                ctrl.mdr_write = (state == ST_MEM_READ);
                ctrl.mem_write = (state == ST_MEM_WRITE);
                ctrl.alu_src_a = 1'b1; // Keep ALU-out on the data address.
                ctrl.alu_src_b = 2'b10;
            end
            ST_WRITEBACK: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            ST_EXEC_R: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_class = CLASS_R_FUNC;
            end
            ST_EXEC_I: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = 2'b10;
                ctrl.alu_class = CLASS_I_FUNC;
            end
            ST_ALU_WRITEBACK: begin
                ctrl.reg_write = 1'b1;
            end
            ST_BRANCH: begin
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_class     = CLASS_BRANCH_CMP;
                ctrl.pc_source     = 1'b1;
                ctrl.pc_write_cond = branch_taken;
            end
            ST_JAL_LINK, ST_JALR_LINK: begin
                ctrl.reg_write = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.alu_src_a = (state == ST_JALR_LINK);
                ctrl.alu_src_b = 2'b10;
            end
            ST_JAL_JUMP, ST_JALR_JUMP: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    assign halted = (state == ST_HALT);

    // A handshake may only finish while the sequencer is waiting for one.
    assert property (@(posedge clk) disable iff (reset)
        mem_done |-> state inside {ST_FETCH, ST_MEM_READ, ST_MEM_WRITE})
        else $error("mem_done seen in state %s", state.name());

    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && state <= ST_HALT)
        else $error("illegal sequencer state %0d", state);

endmodule

`default_nettype wire

// ==== mem_port.sv ====
`default_nettype none

module mem_port #(
    parameter int addr_width = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  cpu_pkg::mem_req_t        cmd_in,
    input  logic                     mem_ack,
    input  logic [cpu_pkg::xlen-1:0] mem_rdata,
    output logic                     mem_req,
    output cpu_pkg::mem_req_t        mem_cmd,
    output logic                     done,
    output logic [cpu_pkg::xlen-1:0] rdata
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        WAIT_ACK_LOW
    } phase_e;

    localparam logic [xlen-1:0] addr_mask = (xlen'(1) << addr_width) - xlen'(1);

    phase_e phase;
    phase_e phase_next;

    always_comb begin
        phase_next = phase;
        case (phase)
            IDLE: begin
                if (start) begin
                    phase_next = REQ;
                end
            end
            REQ: begin
                if (mem_ack) begin
                    phase_next = RELEASE;
                end
            end
            RELEASE: begin
                phase_next = mem_ack ? WAIT_ACK_LOW : IDLE;
            end
            default: begin
                if (!mem_ack) begin
                    phase_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= IDLE;
        end else begin
            phase <= phase_next;
        end
    end

    // The command is frozen for the whole handshake.
    always_ff @(posedge clk) begin
        if (phase == IDLE && start) begin
            mem_cmd <= '{
                addr:     cmd_in.addr & addr_mask,
                wdata:    cmd_in.wdata,
                write_en: cmd_in.write_en
            };
        end
    end

    assign mem_req = (phase == REQ);
    assign done    = (phase == REQ) && mem_ack;
    assign rdata   = done ? mem_rdata : '0; // Bus data is only valid with ack.

    // The bus command holds until both req and ack are low again.
    assert property (@(posedge clk) disable iff (reset)
        (mem_req || mem_ack) |=> $stable(mem_cmd))
        else $error("memory command changed during a handshake");

    assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else $error("new request raised while ack still high");

endmodule

`default_nettype wire

// ==== datapath.sv ====
`default_nettype none

module datapath #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc   = '0,
    parameter int                       addr_width = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_pkg::ctrl_t           ctrl,
    input  logic [cpu_pkg::xlen-1:0] mem_rdata,
    input  logic                     mem_done,
    output cpu_pkg::opcode_e         opcode,
    output logic                     branch_taken,
    output cpu_pkg::mem_req_t        mem_cmd
);
    import cpu_pkg::*;

    // Byte addresses beyond the memory are never reachable.
    localparam int pc_width = addr_width + 2;

    logic [pc_width-1:0] pc;
    logic [pc_width-1:0] pc_old; // Address of the instruction in the IR.
    logic [xlen-1:0]     ir;
    logic [xlen-1:0]     mdr;
    logic [xlen-1:0]     reg_a;
    logic [xlen-1:0]     reg_b;
    logic [xlen-1:0]     alu_out;

    logic [xlen-1:0] read1;
    logic [xlen-1:0] read2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] write_data;
    logic [xlen-1:0] byte_addr;
    logic            zero;

    reg_file rf_i (
        .clk        (clk),
        .reset      (reset),
        .rs1        (ir[19:15]),
        .rs2        (ir[24:20]),
        .rd         (ir[11:7]),
        .write_en   (ctrl.reg_write),
        .write_data (write_data),
        .read1      (read1),
        .read2      (read2)
    );

    imm_gen imm_i (
        .instr (ir),
        .imm   (imm)
    );

    alu_unit alu_i (
        .a         (src_a),
        .b         (src_b),
        .alu_class (ctrl.alu_class),
        .funct3    (ir[14:12]),
        .funct7_5  (ir[30]),
        .result    (alu_result),
        .zero      (zero)
    );

    // While fetching, the ALU steps the PC; afterwards it sees the instruction's address.
    assign src_a = ctrl.alu_src_a ? reg_a : xlen'(ctrl.ir_write ? pc : pc_old);

    always_comb begin
        case (ctrl.alu_src_b)
            2'b00:   src_b = reg_b;
            2'b01:   src_b = xlen'(4);
            default: src_b = imm;
        endcase
    end

    assign pc_next = ctrl.pc_source ? alu_out : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc[pc_width-1:0];
        end else if (ctrl.pc_write || ctrl.pc_write_cond) begin
            pc <= {pc_next[pc_width-1:1], 1'b0}; // jalr clears bit 0.
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write && mem_done) begin
            ir     <= mem_rdata;
            pc_old <= pc;
        end
        if (ctrl.mdr_write && mem_done) begin
            mdr <= mem_rdata;
        end
        reg_a   <= read1;
        reg_b   <= read2;
        alu_out <= alu_result;
    end

    // After fetch the PC already points at the next instruction.
    assign write_data = ctrl.link       ? xlen'(pc) :
                        ctrl.mem_to_reg ? mdr       : alu_out;

    assign opcode       = opcode_e'(ir[6:0]);
    assign branch_taken = ir[12] ? !zero : zero; // bne or beq.

    assign byte_addr        = ctrl.i_or_d ? alu_out : xlen'(pc);
    assign mem_cmd.addr     = {2'b00, byte_addr[xlen-1:2]};
    assign mem_cmd.wdata    = reg_b;
    assign mem_cmd.write_en = ctrl.mem_write;

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`default_nettype none

module cpu_top #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc   = '0,
    parameter int                       addr_width = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_ack,
    input  logic [cpu_pkg::xlen-1:0] mem_rdata,
    output logic                     mem_req,
    output cpu_pkg::mem_req_t        mem_cmd,
    output logic                     halted
);
    import cpu_pkg::*;

    ctrl_t           ctrl;
    opcode_e         opcode;
    logic            branch_taken;
    logic            mem_done;
    logic [xlen-1:0] port_rdata;
    mem_req_t        dp_cmd;

    control_fsm fsm_i (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .mem_done     (mem_done),
        .ctrl         (ctrl),
        .halted       (halted)
    );

    datapath #(
        .reset_pc   (reset_pc),
        .addr_width (addr_width)
    ) dp_i (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .mem_rdata    (port_rdata),
        .mem_done     (mem_done),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .mem_cmd      (dp_cmd)
    );

    mem_port #(
        .addr_width (addr_width)
    ) port_i (
        .clk       (clk),
        .reset     (reset),
        .start     (ctrl.mem_start),
        .cmd_in    (dp_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .done      (mem_done),
        .rdata     (port_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_memory.sv ====
`default_nettype none

module tb_memory #(
    parameter int addr_width = 10
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_req,
    input  cpu_pkg::mem_req_t mem_cmd,
    output logic              mem_ack,
    output logic [31:0]       mem_rdata,
    output logic              store_valid,
    output logic [31:0]       store_addr,
    output logic [31:0]       store_data,
    output logic              proto_err
);
    import cpu_pkg::*;

    localparam int depth           = 2 ** addr_width;
    localparam int release_timeout = 50; // Cycles that mem_req may stay high after ack.

    typedef enum logic [1:0] {
        WAIT_REQ,
        DELAY_ACK,
        WAIT_RELEASE,
        DELAY_DROP
    } mem_phase_e;

    logic [31:0]           mem [depth];
    mem_phase_e            phase;
    int                    delay;
    mem_req_t              held_cmd;
    logic [addr_width-1:0] index;

    assign index = mem_cmd.addr[addr_width-1:0];

    initial begin
        int i;
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        store_valid = 1'b0;
        store_addr  = '0;
        store_data  = '0;
        proto_err   = 1'b0;
        for (i = 0; i < depth; i++) begin
            mem[i] = 32'hdead_0000 ^ 32'(i) ^ (32'(i) << 20);
        end
    end

    always @(posedge clk) begin
        store_valid <= 1'b0;
        proto_err   <= 1'b0;
        if (reset) begin
            phase   <= WAIT_REQ;
            mem_ack <= 1'b0;
            delay   <= 0;
        end else begin
            case (phase)
                WAIT_REQ: begin
                    if (mem_req) begin
                        held_cmd <= mem_cmd;
                        delay    <= $urandom_range(5, 0);
                        phase    <= DELAY_ACK;
                    end
                end
                DELAY_ACK: begin
                    if (!mem_req) begin
                        $display("handshake violation at %0t: mem_req fell before mem_ack", $time);
                        proto_err <= 1'b1;
                        phase     <= WAIT_REQ;
                    end else if (mem_cmd != held_cmd) begin
                        $display("handshake violation at %0t: mem_cmd changed during a request",
                                 $time);
                        proto_err <= 1'b1;
                    end else if (delay == 0) begin
                        if (mem_cmd.write_en) begin
                            mem[index]  <= mem_cmd.wdata;
                            store_valid <= 1'b1;
                            store_addr  <= mem_cmd.addr;
                            store_data  <= mem_cmd.wdata;
                        end
                        mem_rdata <= mem[index]; // Valid for as long as ack stays high.
                        mem_ack   <= 1'b1;
                        phase     <= WAIT_RELEASE;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                WAIT_RELEASE: begin
                    if (!mem_req) begin
                        delay <= $urandom_range(5, 0);
                        phase <= DELAY_DROP;
                    end else if (mem_cmd != held_cmd) begin
                        $display("handshake violation at %0t: mem_cmd changed before release",
                                 $time);
                        proto_err <= 1'b1;
                    end else if (delay == release_timeout) begin
                        $display("handshake violation at %0t: mem_req was never released", $time);
                        proto_err <= 1'b1;
                        mem_ack   <= 1'b0;
                        phase     <= WAIT_REQ;
                    end else begin
                        delay <= delay + 1;
                    end
                end
                default: begin
                    if (mem_req) begin
                        $display("handshake violation at %0t: mem_req rose while mem_ack high",
                                 $time);
                        proto_err <= 1'b1;
                    end
                    if (delay == 0) begin
                        mem_ack <= 1'b0;
                        phase   <= WAIT_REQ;
                    end else begin
                        delay <= delay - 1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam logic [31:0] reset_pc     = 32'h0000_0100;
    localparam int          addr_width   = 10;
    localparam int          n_stores     = 11;
    localparam int          halt_timeout = 5000;
    localparam logic [31:0] data_base    = 32'h0000_0400;
    localparam logic [31:0] c1           = 32'd1234;
    localparam logic [31:0] c2           = -32'd77;

    logic        clk = 1'b0;
    logic        reset;
    logic        mem_req;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    mem_req_t    mem_cmd;
    logic        halted;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        proto_err;

    logic [31:0] exp_addr [n_stores];
    logic [31:0] exp_data [n_stores];
    logic [31:0] want_addr;
    logic [31:0] want_data;
    int          n_expected;
    int          store_count;
    int          prog_word;
    logic        reset_q = 1'b0; // Reset as it was at the previous edge.
    logic        seen_req;
    int          err_store;
    int          err_handshake;
    int          err_control;
    int          err_timeout;

    always #20 clk = ~clk;

    cpu_top #(
        .reset_pc   (reset_pc),
        .addr_width (addr_width)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .halted    (halted)
    );

    tb_memory #(
        .addr_width (addr_width)
    ) mem_i (
        .clk         (clk),
        .reset       (reset),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .proto_err   (proto_err)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] instr);
        mem_i.mem[prog_word] = instr;
        prog_word = prog_word + 1;
    endtask

    task automatic expect_store(input logic [31:0] offset, input logic [31:0] data);
        exp_addr[n_expected] = (data_base + offset) >> 2; // The bus carries word addresses.
        exp_data[n_expected] = data;
        n_expected = n_expected + 1;
    endtask

    assign want_addr = (store_count < n_stores) ? exp_addr[store_count] : '0;
    assign want_data = (store_count < n_stores) ? exp_data[store_count] : '0;

    always @(posedge clk) begin
        reset_q <= reset;
        if (reset) begin
            store_count <= 0;
            seen_req    <= 1'b0;
        end else begin
            if (store_valid) begin
                store_count <= store_count + 1;
            end
            if (mem_req) begin
                seen_req <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !proto_err)
        else begin
            err_handshake++;
            $display("the memory model saw a handshake violation at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (reset) store_valid |-> store_count < n_stores)
        else begin
            err_store++;
            $display("a store beyond the %0d expected ones arrived at %0t", n_stores, $time);
        end

    assert property (@(posedge clk) disable iff (reset)
        store_valid && store_count < n_stores |-> store_addr == want_addr)
        else begin
            err_store++;
            $display("error at %0t: store_addr expected %h got %h",
                     $time, $sampled(want_addr), $sampled(store_addr));
        end

    assert property (@(posedge clk) disable iff (reset)
        store_valid && store_count < n_stores |-> store_data == want_data)
        else begin
            err_store++;
            $display("error at %0t: store_data expected %h got %h",
                     $time, $sampled(want_data), $sampled(store_data));
        end

    // Covers the reset cycles and the first cycle after reset.
    assert property (@(posedge clk) reset_q |-> !mem_req && !halted)
        else begin
            err_control++;
            $display("error at %0t: mem_req expected 0 got %b, halted expected 0 got %b",
                     $time, $sampled(mem_req), $sampled(halted));
        end

    assert property (@(posedge clk) disable iff (reset)
        mem_req && !seen_req |-> !mem_cmd.write_en && mem_cmd.addr == (reset_pc >> 2))
        else begin
            err_control++;
            $display("error at %0t: mem_cmd.addr expected %h got %h, write_en expected 0 got %b",
                     $time, reset_pc >> 2, $sampled(mem_cmd.addr), $sampled(mem_cmd.write_en));
        end

    assert property (@(posedge clk) disable iff (reset) halted |-> !mem_req)
        else begin
            err_control++;
            $display("error at %0t: mem_req expected 0 got 1 after halt", $time);
        end

    initial begin
        int cycles;
        reset = 1'b1;
        void'($urandom(32'h45af));
        prog_word  = reset_pc >> 2;
        n_expected = 0;
        @(posedge clk);

        emit(i_type(c1[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011));   // addi x1, x0, c1
        emit(i_type(c2[11:0], 5'd0, 3'b000, 5'd2, 7'b0010011));   // addi x2, x0, c2
        emit(i_type(data_base[11:0], 5'd0, 3'b000, 5'd10, 7'b0010011));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));            // add
        emit(s_type(12'd0, 5'd3, 5'd10));
        emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));            // sub
        emit(s_type(12'd4, 5'd4, 5'd10));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));            // and
        emit(s_type(12'd8, 5'd5, 5'd10));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));            // or
        emit(s_type(12'd12, 5'd6, 5'd10));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));            // xor
        emit(s_type(12'd16, 5'd7, 5'd10));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));            // slt x8, x2, x1
        emit(s_type(12'd20, 5'd8, 5'd10));
        emit(s_type(12'd24, 5'd1, 5'd10));
        emit(i_type(12'd24, 5'd10, 3'b010, 5'd9, 7'b0000011));    // lw x9, 24(x10)
        emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, 7'b0010011));
        emit(s_type(12'd28, 5'd9, 5'd10));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b000));                  // beq taken
        emit(s_type(12'd32, 5'd2, 5'd10));                        // Skipped marker.
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b001));                  // bne not taken
        emit(s_type(12'd36, 5'd2, 5'd10));
        emit(j_type(21'd8, 5'd11));                               // jal x11, +8
        emit(s_type(12'd40, 5'd2, 5'd10));                        // Skipped marker.
        emit(s_type(12'd44, 5'd11, 5'd10));
        emit(i_type(12'(reset_pc + 32'd116), 5'd0, 3'b000, 5'd12, 7'b0010011));
        emit(i_type(12'd0, 5'd12, 3'b000, 5'd13, 7'b1100111));    // jalr x13, 0(x12)
        emit(s_type(12'd48, 5'd2, 5'd10));                        // Skipped marker.
        emit(s_type(12'd52, 5'd13, 5'd10));
        emit(32'h0000_0073);                                      // ecall

        expect_store(32'd0, c1 + c2);
        expect_store(32'd4, c1 - c2);
        expect_store(32'd8, c1 & c2);
        expect_store(32'd12, c1 | c2);
        expect_store(32'd16, c1 ^ c2);
        expect_store(32'd20, ($signed(c2) < $signed(c1)) ? 32'd1 : 32'd0);
        expect_store(32'd24, c1);
        expect_store(32'd28, c1 + 32'd1);
        expect_store(32'd36, c2);
        expect_store(32'd44, reset_pc + 32'd96);  // jal sits at offset 92.
        expect_store(32'd52, reset_pc + 32'd112); // jalr sits at offset 108.

        repeat (7) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (!halted && cycles < halt_timeout) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (halted) begin
            repeat (20) @(negedge clk); // The bus must stay quiet while halted.
        end else begin
            err_timeout++;
            $display("timeout: the core did not halt within %0d cycles", halt_timeout);
        end

        assert (store_count == n_stores)
            else begin
                err_store++;
                $display("error at %0t: store_count expected %0d got %0d",
                         $time, n_stores, store_count);
            end

        $display("errors: store %0d, handshake %0d, control %0d, timeout %0d",
                 err_store, err_handshake, err_control, err_timeout);
        if (err_store + err_handshake + err_control + err_timeout == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
cpu_pkg.sv
alu_unit.sv
reg_file.sv
imm_gen.sv
control_fsm.sv
mem_port.sv
datapath.sv
cpu_top.sv
tb_memory.sv
tb_cpu.sv
